//--- Makefile
# Verilator build and run of the modulus unit testbench

TOP := mod_unit_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f files.f -o Vsim

# Fails unless the pass line shows up in the simulator output
run: compile
	@out="$$(./obj_dir/Vsim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf obj_dir

//--- common/mod_ctrl_pkg.sv
//--------------------------------------------------------------------------
// State encoding of the request sequencer FSM
//--------------------------------------------------------------------------

`default_nettype none

package mod_ctrl_pkg;

	// One request in flight with a fixed two cycle latency
	typedef enum logic [1:0]
	{
		ST_IDLE = 2'd0,  // Waiting for start
		ST_EVAL = 2'd1,  // Operands registered, remainder settling
		ST_DONE = 2'd2   // Result valid, done high
	} seq_state_t;

endpackage : mod_ctrl_pkg

`default_nettype wire

//--- common/mod_types_pkg.sv
//--------------------------------------------------------------------------
// Default operand widths and the modulus opcode enum
//--------------------------------------------------------------------------

`default_nettype none

package mod_types_pkg;

	// Operand widths used as top level parameter defaults
	localparam int a_width_def = 14;  // Dividend width
	localparam int b_width_def = 9;   // Divisor and remainder width

	// Opcode of a request
	// Selects how both operands and the result are interpreted
	typedef enum logic [0:0]
	{
		OP_MODU = 1'b0,  // Unsigned operands
		OP_MODS = 1'b1   // Two's complement operands with the result signed like a
	} mod_op_t;

endpackage : mod_types_pkg

`default_nettype wire

//--- design/mod_sequencer.sv
//--------------------------------------------------------------------------
// Request capture, opcode decode and result register of the modulus unit,
// with protocol assertions
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module mod_sequencer #(
	parameter int A_WIDTH = mod_types_pkg::a_width_def,  // Dividend width
	parameter int B_WIDTH = mod_types_pkg::b_width_def,  // Divisor width
	parameter int TC_MODE = 1                            // 0 removes signed support
) (
	input  wire logic                  clk,
	input  wire logic                  rst_n,     // Synchronous, active low
	input  wire logic                  start,     // One cycle request strobe
	input  wire mod_types_pkg::mod_op_t op,       // Sampled with start
	input  wire logic [A_WIDTH-1:0]    a,         // Dividend, sampled with start
	input  wire logic [B_WIDTH-1:0]    b,         // Divisor, sampled with start
	input  wire logic [B_WIDTH-1:0]    mod_comb,  // Remainder from ver_mod
	output logic      [A_WIDTH-1:0]    a_q,       // Registered dividend
	output logic      [B_WIDTH-1:0]    b_q,       // Registered divisor
	output logic                       tc_q,      // Registered signed flag
	output logic                       busy,      // Request in flight
	output logic                       done,      // Result valid for one cycle
	output logic      [B_WIDTH-1:0]    modulus,   // Held until next result
	output logic                       div_zero   // Held with modulus
);

	import mod_types_pkg::*;
	import mod_ctrl_pkg::*;

	seq_state_t state;
	logic       accept;  // Start taken this cycle

	assign accept = start && (state == ST_IDLE);  // Start while busy is dropped
	assign busy   = (state != ST_IDLE);
	assign done   = (state == ST_DONE);

	//--------------------------------------------------------------------------
	// FSM
	//--------------------------------------------------------------------------

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			state <= ST_IDLE;
		else
		begin
			case (state)
				ST_IDLE:
				begin
					if (accept)
						state <= ST_EVAL;
				end
				ST_EVAL: state <= ST_DONE;  // ver_mod has settled on the registered operands
				ST_DONE: state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	//--------------------------------------------------------------------------
	// Operand capture and opcode decode
	//--------------------------------------------------------------------------

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			a_q  <= a;
			b_q  <= b;
			tc_q <= (op == OP_MODS) && (TC_MODE != 0);  // Signed requests fall back to unsigned
		end
	end

	// Result register loaded once per request
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			modulus  <= '0;
			div_zero <= 1'b0;
		end
		else if (state == ST_EVAL)
		begin
			modulus  <= mod_comb;
			div_zero <= (b_q == '0);
		end
	end

	//--------------------------------------------------------------------------
	// Assertions
	//--------------------------------------------------------------------------

	// Single cycle done pulse
	a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		done |=> !done)
	else $error("mod_sequencer: done high for more than one cycle");

	// Fixed latency from an accepted start
	a_done_latency: assert property (@(posedge clk) disable iff (!rst_n)
		(start && !busy) |-> ##2 done)
	else $error("mod_sequencer: done did not follow start by two cycles");

	// Reset leaves the unit idle
	a_reset_idle: assert property (@(posedge clk)
		!rst_n |=> !busy)
	else $error("mod_sequencer: busy after reset");

endmodule : mod_sequencer

`default_nettype wire

//--- design/mod_unit_top.sv
//--------------------------------------------------------------------------
// Modulus unit top level, sequencer plus combinational modulus block
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module mod_unit_top #(
	parameter int A_WIDTH = mod_types_pkg::a_width_def,  // Dividend width
	parameter int B_WIDTH = mod_types_pkg::b_width_def,  // Divisor and result width
	parameter int TC_MODE = 1                            // 0 treats all requests as unsigned
) (
	input  wire logic                   clk,
	input  wire logic                   rst_n,
	input  wire logic                   start,
	input  wire mod_types_pkg::mod_op_t op,
	input  wire logic [A_WIDTH-1:0]     a,
	input  wire logic [B_WIDTH-1:0]     b,
	output logic                        busy,
	output logic                        done,
	output logic      [B_WIDTH-1:0]     modulus,
	output logic                        div_zero
);

	// Registered operands toward ver_mod
	logic [A_WIDTH-1:0] a_q;
	logic [B_WIDTH-1:0] b_q;
	logic               tc_q;
	logic [B_WIDTH-1:0] mod_comb;  // Remainder back to the sequencer

	mod_sequencer #(
		.A_WIDTH (A_WIDTH),
		.B_WIDTH (B_WIDTH),
		.TC_MODE (TC_MODE)
	) u_seq (
		.clk      (clk),
		.rst_n    (rst_n),
		.start    (start),
		.op       (op),
		.a        (a),
		.b        (b),
		.mod_comb (mod_comb),
		.a_q      (a_q),
		.b_q      (b_q),
		.tc_q     (tc_q),
		.busy     (busy),
		.done     (done),
		.modulus  (modulus),
		.div_zero (div_zero)
	);

	// Zero cycle datapath between the two registers of the sequencer
	ver_mod #(
		.A_WIDTH (A_WIDTH),
		.B_WIDTH (B_WIDTH),
		.TC_MODE (TC_MODE)
	) u_mod (
		.a       (a_q),
		.b       (b_q),
		.tc      (tc_q),
		.modulus (mod_comb)
	);

endmodule : mod_unit_top

`default_nettype wire

//--- design/ver_mod.sv
//--------------------------------------------------------------------------
// Combinational Verilog-style modulus, unsigned or two's complement,
// built on a non-restoring shift/subtract remainder
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module ver_mod #(
	parameter int A_WIDTH = mod_types_pkg::a_width_def,  // Dividend width
	parameter int B_WIDTH = mod_types_pkg::b_width_def,  // Divisor width
	parameter int TC_MODE = 1                            // 0 removes signed support
) (
	input  wire logic [A_WIDTH-1:0] a,       // Dividend
	input  wire logic [B_WIDTH-1:0] b,       // Divisor
	input  wire logic               tc,      // Two's complement request
	output logic      [B_WIDTH-1:0] modulus  // a mod b, sign of a
);

	//--------------------------------------------------------------------------
	// Remainder of two unsigned magnitudes
	//--------------------------------------------------------------------------

	// Non-restoring division lets the partial remainder go negative
	// and the next step then adds b instead of subtracting it.
	// One extra bit holds the sign of the partial remainder
	function automatic logic [B_WIDTH-1:0] nr_rem(
		input logic [A_WIDTH-1:0] dvd,
		input logic [B_WIDTH-1:0] dvs
	);
		logic [B_WIDTH:0] part;   // Partial remainder, two's complement
		logic [B_WIDTH:0] dvs_x;  // Divisor zero extended to remainder width
		begin
			part  = '0;
			dvs_x = {1'b0, dvs};
			// Bring dividend bits in MSB first
			for (int i = A_WIDTH - 1; i >= 0; i--)
			begin
				if (part[B_WIDTH])
					part = {part[B_WIDTH-1:0], dvd[i]} + dvs_x;  // Negative, add back
				else
					part = {part[B_WIDTH-1:0], dvd[i]} - dvs_x;  // Positive, subtract
			end
			// Final correction into [0, b)
			if (part[B_WIDTH])
				part = part + dvs_x;
			return part[B_WIDTH-1:0];
		end
	endfunction

	//--------------------------------------------------------------------------
	// Sign handling around the unsigned core
	//--------------------------------------------------------------------------

	logic               signed_op;  // Operands taken as two's complement
	logic               a_neg;      // Dividend is negative
	logic               b_neg;      // Divisor is negative
	logic [A_WIDTH-1:0] mag_a;      // Dividend magnitude
	logic [B_WIDTH-1:0] mag_b;      // Divisor magnitude
	logic [B_WIDTH-1:0] rem_u;      // Remainder of the magnitudes

	assign signed_op = tc && (TC_MODE != 0);
	assign a_neg     = signed_op && a[A_WIDTH-1];
	assign b_neg     = signed_op && b[B_WIDTH-1];

	// Most negative value maps onto itself and reads back as the right
	// unsigned magnitude
	assign mag_a = a_neg ? (~a + 1'b1) : a;
	assign mag_b = b_neg ? (~b + 1'b1) : b;

	assign rem_u = nr_rem(mag_a, mag_b);

	// Result follows the sign of the dividend and is 0 for a zero divisor
	always_comb
	begin
		if (b == '0)
			modulus = '0;
		else if (a_neg && (rem_u != '0))
			modulus = ~rem_u + 1'b1;  // Negate nonzero remainder
		else
			modulus = rem_u;

		// Unsigned remainder must land below the divisor
		if (!tc && (b != '0))
		begin
			assert (modulus < b)
			else $error("ver_mod: unsigned remainder %0d not below divisor %0d", modulus, b);
		end
	end

endmodule : ver_mod

`default_nettype wire

//--- files.f
common/mod_types_pkg.sv
common/mod_ctrl_pkg.sv
design/ver_mod.sv
design/mod_sequencer.sv
design/mod_unit_top.sv
testbench/tb_clock_gen.sv
testbench/mod_unit_tb.sv

//--- testbench/mod_unit_tb.sv
//--------------------------------------------------------------------------
// Testbench of the modulus unit, random and directed requests checked
// against a reference modulus, with a watchdog
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module mod_unit_tb;

	import mod_types_pkg::*;

	localparam int A_W = a_width_def;
	localparam int B_W = b_width_def;

	// Request counts that also size the watchdog
	localparam int n_random     = 40;  // Per opcode
	localparam int n_zero       = 4;
	localparam int n_timing     = 3;
	localparam int n_busy       = 2;
	localparam int n_edge       = 12;
	localparam int num_requests = 2 * n_random + n_zero + n_timing + n_busy + n_edge;
	localparam int timeout_cycles = 5 + num_requests * 10 + 100;  // Reset, requests, margin

	logic           clk;
	logic           rst_n;
	logic           start;
	mod_op_t        op;
	logic [A_W-1:0] a;
	logic [B_W-1:0] b;
	logic           busy;
	logic           done;
	logic [B_W-1:0] modulus;
	logic           div_zero;

	// Expected results in request order
	logic [B_W-1:0] exp_mod_q[$];
	logic           exp_dz_q[$];
	string          exp_name_q[$];

	logic [31:0] lcg_state = 32'd29647;  // Fixed seed
	string       current_test;
	int          test_count;
	int          test_checks;
	int          test_errors;
	int          check_count;
	int          error_count;
	int          done_count;  // Done pulses seen by the compare process

	tb_clock_gen #(.PERIOD_NS(100)) u_clk (.clk(clk));

	mod_unit_top #(
		.A_WIDTH (A_W),
		.B_WIDTH (B_W),
		.TC_MODE (1)
	) DUT (
		.clk      (clk),
		.rst_n    (rst_n),
		.start    (start),
		.op       (op),
		.a        (a),
		.b        (b),
		.busy     (busy),
		.done     (done),
		.modulus  (modulus),
		.div_zero (div_zero)
	);

	//--------------------------------------------------------------------------
	// Reference model and helpers
	//--------------------------------------------------------------------------

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// Remainder takes the sign of a and is zero for a zero divisor
	function automatic logic [B_W-1:0] ref_modulus(
		input logic [A_W-1:0] a_in,
		input logic [B_W-1:0] b_in,
		input logic           signed_req
	);
		int sa;
		int sb;
		int r;
		begin
			if (signed_req)
			begin
				sa = {{(32-A_W){a_in[A_W-1]}}, a_in};  // Sign extend
				sb = {{(32-B_W){b_in[B_W-1]}}, b_in};
			end
			else
			begin
				sa = {{(32-A_W){1'b0}}, a_in};
				sb = {{(32-B_W){1'b0}}, b_in};
			end
			if (sb == 0)
				return '0;
			r = sa % sb;  // Integer % keeps the dividend sign
			return r[B_W-1:0];
		end
	endfunction

	task automatic compare_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		check_count++;
		test_checks++;
		if (expected !== actual)
		begin
			error_count++;
			test_errors++;
			$display("error: %s expected 0x%0h actual 0x%0h", what, expected, actual);
		end
	endtask

	task automatic draw_operands(output logic [A_W-1:0] ra, output logic [B_W-1:0] rb);
		lcg_state = lcg_next(lcg_state);
		ra        = lcg_state[A_W+15:16];  // Upper bits have the longer period
		lcg_state = lcg_next(lcg_state);
		rb        = lcg_state[B_W+15:16];
	endtask

	task automatic begin_test(input string name);
		current_test = name;
		test_checks  = 0;
		test_errors  = 0;
	endtask

	task automatic end_test();
		test_count++;
		$display("test %-10s checks %4d errors %3d  %s", current_test, test_checks,
			test_errors, (test_errors == 0) ? "ok" : "FAIL");
	endtask

	// Drive one start strobe on the falling edge and log its expected result
	task automatic issue_request(input mod_op_t op_in, input logic [A_W-1:0] a_in,
		input logic [B_W-1:0] b_in);
		@(negedge clk);
		start = 1'b1;
		op    = op_in;
		a     = a_in;
		b     = b_in;
		exp_mod_q.push_back(ref_modulus(a_in, b_in, op_in == OP_MODS));
		exp_dz_q.push_back(b_in == '0);
		exp_name_q.push_back(current_test);
		@(negedge clk);
		start = 1'b0;
	endtask

	task automatic wait_idle();
		while (busy)
			@(negedge clk);  // Watchdog ends a hang
	endtask

	task automatic run_request(input mod_op_t op_in, input logic [A_W-1:0] a_in,
		input logic [B_W-1:0] b_in);
		issue_request(op_in, a_in, b_in);
		wait_idle();
	endtask

	// Count cycles from the accepting edge to done
	task automatic check_timing(input mod_op_t op_in, input logic [A_W-1:0] a_in,
		input logic [B_W-1:0] b_in);
		int cycles;
		begin
			issue_request(op_in, a_in, b_in);
			cycles = 1;  // One edge past the accepting one
			while (!done && cycles < 8)
			begin
				compare_value("timing busy before done", 32'd1, 32'(busy));
				@(negedge clk);
				cycles++;
			end
			compare_value("timing start to done cycles", 32'd2, 32'(cycles));
			compare_value("timing busy with done", 32'd1, 32'(busy));
			@(negedge clk);
			compare_value("timing done width", 32'd0, 32'(done));
			compare_value("timing busy after done", 32'd0, 32'(busy));
		end
	endtask

	//--------------------------------------------------------------------------
	// Compare process
	//--------------------------------------------------------------------------

	always @(negedge clk)
	begin : compare_results
		string          req_name;
		logic [B_W-1:0] exp_mod;
		logic           exp_dz;
		if (rst_n && done)
		begin
			done_count++;
			if (exp_mod_q.size() == 0)
			begin
				error_count++;
				test_errors++;
				$display("done pulse arrived with no request outstanding");
			end
			else
			begin
				req_name = exp_name_q.pop_front();
				exp_mod  = exp_mod_q.pop_front();
				exp_dz   = exp_dz_q.pop_front();
				compare_value({req_name, " modulus"}, 32'(exp_mod), 32'(modulus));
				compare_value({req_name, " div_zero"}, 32'(exp_dz), 32'(div_zero));
			end
		end
	end

	//--------------------------------------------------------------------------
	// Watchdog
	//--------------------------------------------------------------------------

	initial
	begin
		repeat (timeout_cycles) @(posedge clk);
		$display("timeout: done never arrived within %0d cycles", timeout_cycles);
		$display("Regression failed");
		$finish;
	end

	//--------------------------------------------------------------------------
	// Stimulus
	//--------------------------------------------------------------------------

	initial
	begin : stimulus
		logic [A_W-1:0] ra;
		logic [B_W-1:0] rb;
		int             dones_before;

		rst_n = 1'b0;
		start = 1'b0;
		op    = OP_MODU;
		a     = '0;
		b     = '0;
		test_count  = 0;
		check_count = 0;
		error_count = 0;
		done_count  = 0;
		repeat (5) @(posedge clk);  // Reset held for 5 cycles
		@(negedge clk);
		rst_n = 1'b1;

		begin_test("unsigned");
		for (int i = 0; i < n_random; i++)
		begin
			draw_operands(ra, rb);
			run_request(OP_MODU, ra, rb);
		end
		end_test();

		begin_test("signed");  // Both signs of a and b from the random bits
		for (int i = 0; i < n_random; i++)
		begin
			draw_operands(ra, rb);
			run_request(OP_MODS, ra, rb);
		end
		end_test();

		begin_test("div_zero");
		draw_operands(ra, rb);
		run_request(OP_MODU, ra, '0);
		run_request(OP_MODS, ra, '0);
		run_request(OP_MODS, 14'h2000, '0);
		run_request(OP_MODU, '0, '0);
		end_test();

		begin_test("timing");
		check_timing(OP_MODU, 14'd1234, 9'd37);
		check_timing(OP_MODS, 14'h3F00, 9'h1F3);
		check_timing(OP_MODS, 14'd77, '0);
		end_test();

		// Second strobe lands in EVAL and the third in DONE where both are dropped
		begin_test("busy_drop");
		dones_before = done_count;
		issue_request(OP_MODU, 14'd5000, 9'd123);
		start = 1'b1;
		op    = OP_MODS;
		a     = 14'h3FFF;
		b     = 9'd2;
		@(negedge clk);
		start = 1'b1;  // Still busy in DONE
		@(negedge clk);
		start = 1'b0;
		repeat (4) @(negedge clk);
		compare_value("busy_drop done pulses", 32'd1, 32'(done_count - dones_before));
		end_test();

		begin_test("edge");
		run_request(OP_MODU, '0, 9'd7);
		run_request(OP_MODS, '0, 9'h1F9);
		run_request(OP_MODS, 14'h2000, 9'd3);     // Most negative a
		run_request(OP_MODS, 14'h2000, 9'h1FF);
		run_request(OP_MODS, 14'h2000, 9'h100);   // Most negative b as well
		run_request(OP_MODU, 14'h2000, 9'd3);
		run_request(OP_MODU, 14'h3FFF, 9'd1);
		run_request(OP_MODS, 14'h3FFF, 9'd1);
		run_request(OP_MODU, 14'd100, 9'd100);   // a equal to b
		run_request(OP_MODS, 14'h3FFB, 9'h1FB);
		run_request(OP_MODU, 14'd511, 9'd511);
		run_request(OP_MODS, 14'h1FFF, 9'h0FF);
		end_test();

		repeat (3) @(negedge clk);
		if (exp_mod_q.size() != 0)
		begin
			error_count++;
			$display("%0d requests never produced a result", exp_mod_q.size());
		end

		$display("tests %0d  checks %0d  errors %0d", test_count, check_count, error_count);
		if (error_count == 0)
		begin
			$display("Regression passed");
		end
		else
		begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule : mod_unit_tb

`default_nettype wire

//--- testbench/tb_clock_gen.sv
//--------------------------------------------------------------------------
// Free running testbench clock
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD_NS = 100  // Full clock period
) (
	output logic clk
);

	initial
	begin
		clk = 1'b0;  // Known level before the first edge
	end

	always #(PERIOD_NS / 2) clk = ~clk;  // Half period per phase

endmodule : tb_clock_gen

`default_nettype wire
